// File: exec_pkg.sv
// shared types for the execute stage; all ops are single cycle, only modes listed here are decoded
package exec_pkg;

	typedef logic [31:0] word_t;     // operand / result word
	typedef logic [4:0]  mode_t;     // major op code
	typedef logic [1:0]  sub_mode_t;
	typedef logic [4:0]  bit_idx_t;  // field bound
	typedef logic [3:0]  y1_chan_t;  // y1 destination select
	typedef logic [1:0]  y2_chan_t;  // 0 none, 1 flag, 2 sp
	typedef logic [7:0]  irq_num_t;

	// major modes still handled here
	localparam mode_t MODE_CONV  = 5'd4;  // only negate (sub 3)
	localparam mode_t MODE_SHIFT = 5'd5;
	localparam mode_t MODE_LOGIC = 5'd6;
	localparam mode_t MODE_MOVE  = 5'd9;
	localparam mode_t MODE_SEXT  = 5'd18;
	localparam mode_t MODE_FIELD = 5'd19;
	localparam mode_t MODE_CMPU  = 5'd20;
	localparam mode_t MODE_CMPS  = 5'd21;

	localparam word_t SHIFT_MAX = 32'd32; // amounts above this fault

	localparam irq_num_t IRQ_SHIFT_LEFT  = 8'd6;
	localparam irq_num_t IRQ_SHIFT_RIGHT = 8'd7;

	// request from the upstream stage
	typedef struct packed {
		mode_t     mode;
		sub_mode_t sub_mode;
		logic      rw;       // extends sub_mode for compares
		word_t     x1;
		word_t     x2;
		bit_idx_t  m_num;    // upper field bound
		bit_idx_t  l_num;    // lower field bound
		y1_chan_t  y1_sel;
		y2_chan_t  y2_sel;
	} exec_req_t;

	// passes through unchanged, one cycle late
	typedef struct packed {
		word_t order_addr;
		logic  running;
		logic  dep_tpc;
		logic  dep_ipc;
		logic  eff_tpc;
		logic  eff_ipc;
		logic  eff_flag;
		logic  eff_cs;
		logic  four_cycle;
	} exec_tag_t;

	typedef struct packed {
		word_t y1;
		word_t y2;
	} unit_res_t;

	typedef struct packed {
		word_t    y1;
		word_t    y2;
		y1_chan_t y1_channel;
		y2_chan_t y2_channel;
	} exec_result_t;

	typedef struct packed {
		logic     valid;
		irq_num_t num;
	} irq_t;

	// {rw, sub_mode}; codes 6 and 7 are unused
	typedef enum logic [2:0] {
		EQ = 3'd0,
		NE = 3'd1,
		GT = 3'd2,
		LT = 3'd3,
		GE = 3'd4,
		LE = 3'd5
	} cmp_cond_t;

endpackage

// File: shift_unit.sv
// combinational shifts/rotates; x2 is the amount, anything above 32 raises a fault
`timescale 1ns/1ns

module shift_unit (
	input  exec_pkg::exec_req_t req,
	output exec_pkg::unit_res_t res,
	output logic                fault,
	output exec_pkg::irq_num_t  fault_num
);

	logic [63:0] wide_l; // {spill, shifted}
	logic [63:0] wide_r; // {shifted, dropped}

	assign wide_l = {32'b0, req.x1} << req.x2;
	assign wide_r = {req.x1, 32'b0} >> req.x2;

	always_comb begin
		case (req.sub_mode)
			2'd0: begin // shl
				res.y1 = wide_l[31:0];
				res.y2 = wide_l[63:32];
			end
			2'd1: begin // shr with the lost bits at the top of y2
				res.y1 = wide_r[63:32];
				res.y2 = wide_r[31:0];
			end
			2'd2: begin // rol
				res.y1 = wide_l[31:0] | wide_l[63:32];
				res.y2 = wide_l[63:32];
			end
			default: begin // ror
				res.y1 = wide_r[63:32] | wide_r[31:0];
				res.y2 = wide_r[31:0];
			end
		endcase
	end

	assign fault = (req.mode == exec_pkg::MODE_SHIFT) && (req.x2 > exec_pkg::SHIFT_MAX);

	// odd subs go right
	assign fault_num = req.sub_mode[0] ? exec_pkg::IRQ_SHIFT_RIGHT : exec_pkg::IRQ_SHIFT_LEFT;

endmodule

// File: bitop_unit.sv
// combinational logic, field, move, sign-extend and negate; field ops expect m_num >= l_num
`timescale 1ns/1ns

module bitop_unit (
	input  exec_pkg::exec_req_t req,
	output exec_pkg::unit_res_t res
);

	exec_pkg::word_t field_mask;
	logic            x1_true;
	logic            x2_true;

	// ones from m_num down to l_num
	assign field_mask = (32'hffff_ffff >> (5'd31 - req.m_num)) & (32'hffff_ffff << req.l_num);

	assign x1_true = |req.x1;
	assign x2_true = |req.x2;

	always_comb begin
		res = '0;
		case (req.mode)
			exec_pkg::MODE_LOGIC: begin
				case (req.sub_mode)
					2'd0: begin
						res.y1    = req.x1 & req.x2;
						res.y2[0] = x1_true && x2_true;
					end
					2'd1: begin
						res.y1    = req.x1 | req.x2;
						res.y2[0] = x1_true || x2_true;
					end
					2'd2: begin // unary on x2
						res.y1    = ~req.x2;
						res.y2[0] = !x2_true;
					end
					default: begin
						res.y1    = req.x1 ^ req.x2;
						res.y2[0] = x1_true ^ x2_true;
					end
				endcase
			end
			exec_pkg::MODE_FIELD: begin
				if (req.sub_mode == 2'd0)
					res.y1 = (req.x1 & ~field_mask) | ((req.x2 << req.l_num) & field_mask);
				else if (req.sub_mode == 2'd1)
					res.y1 = (req.x2 & field_mask) >> req.l_num; // right-aligned get
			end
			exec_pkg::MODE_MOVE: begin
				if (req.sub_mode == 2'd0)
					res.y1 = req.x2;
				else if (req.sub_mode == 2'd1)
					res.y1 = (req.x1 << 16) | req.x2; // move-high
			end
			exec_pkg::MODE_SEXT: begin
				if (req.sub_mode == 2'd0)
					res.y1 = req.x2[7] ? {24'hff_ffff, req.x2[7:0]} : req.x2;
				else if (req.sub_mode == 2'd1)
					res.y1 = req.x2[15] ? {16'hffff, req.x2[15:0]} : req.x2;
			end
			exec_pkg::MODE_CONV: begin
				if (req.sub_mode == 2'd3)
					res.y1 = ~req.x2 + 32'd1;
			end
			default: res = '0;
		endcase
	end

endmodule

// File: compare_unit.sv
// six-way integer compare with the result in y2 bit 0; signed only in MODE_CMPS
`timescale 1ns/1ns

module compare_unit (
	input  exec_pkg::exec_req_t req,
	output exec_pkg::unit_res_t res
);

	exec_pkg::cmp_cond_t cond;
	logic                eq;
	logic                lt;
	logic                gt;
	logic                hit;

	assign cond = exec_pkg::cmp_cond_t'({req.rw, req.sub_mode});

	assign eq = (req.x1 == req.x2);

	always_comb begin
		if (req.mode == exec_pkg::MODE_CMPS)
			lt = $signed(req.x1) < $signed(req.x2);
		else
			lt = req.x1 < req.x2;
	end

	assign gt = !lt && !eq;

	always_comb begin
		case (cond)
			exec_pkg::EQ: hit = eq;
			exec_pkg::NE: hit = !eq;
			exec_pkg::GT: hit = gt;
			exec_pkg::LT: hit = lt;
			exec_pkg::GE: hit = !lt;
			exec_pkg::LE: hit = !gt;
			default: hit = 1'b0; // codes 6, 7
		endcase
	end

	// y1 unused by compares
	assign res.y1 = '0;
	assign res.y2 = {31'b0, hit};

endmodule

// File: exec_pipe_reg.sv
// stage output registers; hold freezes everything, upstream irq wins over the local one
`timescale 1ns/1ns

module exec_pipe_reg (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   hold,
	input  exec_pkg::exec_result_t res_in,
	input  exec_pkg::exec_tag_t    tag_in,
	input  exec_pkg::irq_t         irq_in,
	input  exec_pkg::irq_t         irq_local,
	output exec_pkg::exec_result_t result,
	output exec_pkg::exec_tag_t    tag_out,
	output exec_pkg::irq_t         irq_out
);

	exec_pkg::irq_t irq_merged;

	assign irq_merged = irq_in.valid ? irq_in : irq_local;

	always_ff @(posedge clk) begin
		if (rst) begin
			result  <= '0;
			tag_out <= '0;
			irq_out <= '0;
		end else if (!hold) begin
			result  <= res_in;
			tag_out <= tag_in;
			irq_out <= irq_merged;
		end
	end

endmodule

// File: exec_stage.sv
// execute stage top with one cycle of latency; no handshake, upstream keeps req stable while hold is high
`timescale 1ns/1ns

module exec_stage (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   hold,
	input  exec_pkg::exec_req_t    req,
	input  exec_pkg::exec_tag_t    tag_in,
	input  exec_pkg::irq_t         irq_in,
	output exec_pkg::exec_result_t result,
	output exec_pkg::exec_tag_t    tag_out,
	output exec_pkg::irq_t         irq_out
);

	exec_pkg::unit_res_t    shift_res;
	exec_pkg::unit_res_t    bitop_res;
	exec_pkg::unit_res_t    cmp_res;
	exec_pkg::unit_res_t    sel_res;
	logic                   shift_fault;
	exec_pkg::irq_num_t     shift_fault_num;
	logic                   supported;
	exec_pkg::exec_result_t res_comb;
	exec_pkg::irq_t         irq_local;

	shift_unit shift_unit_i (
		.req       (req),
		.res       (shift_res),
		.fault     (shift_fault),
		.fault_num (shift_fault_num)
	);

	bitop_unit bitop_unit_i (
		.req (req),
		.res (bitop_res)
	);

	compare_unit compare_unit_i (
		.req (req),
		.res (cmp_res)
	);

	// mode decode and result select
	always_comb begin
		supported = 1'b0;
		sel_res   = '0;
		case (req.mode)
			exec_pkg::MODE_SHIFT: begin
				supported = 1'b1;
				sel_res   = shift_res;
			end
			exec_pkg::MODE_LOGIC: begin
				supported = 1'b1;
				sel_res   = bitop_res;
			end
			exec_pkg::MODE_MOVE, exec_pkg::MODE_SEXT, exec_pkg::MODE_FIELD: begin
				supported = !req.sub_mode[1]; // subs 0 and 1 only
				sel_res   = bitop_res;
			end
			exec_pkg::MODE_CONV: begin
				supported = (req.sub_mode == 2'd3); // negate only
				sel_res   = bitop_res;
			end
			exec_pkg::MODE_CMPU, exec_pkg::MODE_CMPS: begin
				supported = 1'b1;
				sel_res   = cmp_res;
			end
			default: supported = 1'b0;
		endcase
		if (!supported)
			sel_res = '0;
	end

	always_comb begin
		res_comb.y1 = sel_res.y1;
		res_comb.y2 = sel_res.y2;
		if (supported && !shift_fault) begin
			res_comb.y1_channel = req.y1_sel;
			res_comb.y2_channel = req.y2_sel;
		end else begin
			res_comb.y1_channel = '0; // nothing written back
			res_comb.y2_channel = '0;
		end
	end

	assign irq_local.valid = shift_fault;
	assign irq_local.num   = shift_fault ? shift_fault_num : '0;

	exec_pipe_reg exec_pipe_reg_i (
		.clk       (clk),
		.rst       (rst),
		.hold      (hold),
		.res_in    (res_comb),
		.tag_in    (tag_in),
		.irq_in    (irq_in),
		.irq_local (irq_local),
		.result    (result),
		.tag_out   (tag_out),
		.irq_out   (irq_out)
	);

endmodule

// File: exec_stage_sva.sv
// bound into exec_stage; fault is the shift unit fault, sampled on the rising clk edge
`timescale 1ns/1ns

module exec_stage_sva (
	input logic                   clk,
	input logic                   rst,
	input logic                   hold,
	input logic                   fault,
	input exec_pkg::exec_result_t result,
	input exec_pkg::exec_tag_t    tag_out,
	input exec_pkg::irq_t         irq_out
);

	reset_clears: assert property (@(posedge clk)
		rst |=> (result == '0 && tag_out == '0 && irq_out == '0))
		else $error("outputs not cleared one cycle after reset");

	// no write-back after a shift fault
	fault_zero_chan: assert property (@(posedge clk)
		(fault && !hold && !rst) |=> (result.y1_channel == '0 && result.y2_channel == '0))
		else $error("channels not zero after a shift fault");

	hold_freezes: assert property (@(posedge clk)
		(hold && !rst) |=> ($stable(result) && $stable(irq_out)))
		else $error("result or irq_out changed while hold was high");

endmodule

// File: exec_stage_tb.sv
// expects exec_patterns.txt in the run directory (project root); one line per cycle, checked a cycle later
`timescale 1ns/1ns

module exec_stage_tb;

	typedef struct packed {
		logic                   hold;
		exec_pkg::exec_req_t    req;
		exec_pkg::exec_tag_t    tag;
		exec_pkg::irq_t         irq;
		exec_pkg::exec_result_t exp;
		exec_pkg::irq_t         exp_irq;
	} pattern_t;

	logic                   clk;
	logic                   rst;
	logic                   hold;
	exec_pkg::exec_req_t    req;
	exec_pkg::exec_tag_t    tag_in;
	exec_pkg::irq_t         irq_in;
	exec_pkg::exec_result_t result;
	exec_pkg::exec_tag_t    tag_out;
	exec_pkg::irq_t         irq_out;
	exec_pkg::exec_tag_t    exp_tag; // tag of the last line with hold low

	pattern_t pats[$];
	int       errors = 0;
	bit       loaded = 1'b0;

	exec_stage exec_stage_i (
		.clk     (clk),
		.rst     (rst),
		.hold    (hold),
		.req     (req),
		.tag_in  (tag_in),
		.irq_in  (irq_in),
		.result  (result),
		.tag_out (tag_out),
		.irq_out (irq_out)
	);

	bind exec_stage exec_stage_sva exec_stage_sva_i (
		.clk     (clk),
		.rst     (rst),
		.hold    (hold),
		.fault   (shift_fault),
		.result  (result),
		.tag_out (tag_out),
		.irq_out (irq_out)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic load_patterns();
		int          fd;
		int          n;
		string       line;
		logic [31:0] v [20];
		pattern_t    p;
		fd = $fopen("exec_patterns.txt", "r");
		if (fd == 0) begin
			$display("could not open exec_patterns.txt");
			errors++;
			return;
		end
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
				v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8], v[9],
				v[10], v[11], v[12], v[13], v[14], v[15], v[16], v[17], v[18], v[19]);
			if (n != 20)
				continue; // comment or blank line
			p.hold           = v[0][0];
			p.req.mode       = v[1][4:0];
			p.req.sub_mode   = v[2][1:0];
			p.req.rw         = v[3][0];
			p.req.x1         = v[4];
			p.req.x2         = v[5];
			p.req.m_num      = v[6][4:0];
			p.req.l_num      = v[7][4:0];
			p.req.y1_sel     = v[8][3:0];
			p.req.y2_sel     = v[9][1:0];
			p.tag            = {v[10], v[11][7:0]};
			p.irq            = {v[12][0], v[13][7:0]};
			p.exp.y1         = v[14];
			p.exp.y2         = v[15];
			p.exp.y1_channel = v[16][3:0];
			p.exp.y2_channel = v[17][1:0];
			p.exp_irq        = {v[18][0], v[19][7:0]};
			pats.push_back(p);
		end
		$fclose(fd);
		if (pats.size() == 0) begin
			$display("no pattern lines were read from exec_patterns.txt");
			errors++;
		end
	endtask

	task automatic check_line(input int idx, input pattern_t p, input exec_pkg::exec_tag_t etag);
		assert (result === p.exp) else begin
			errors++;
			$display("[ERROR] %0t ns: pattern %0d y1 %h y2 %h ch %h/%h, expected %h %h ch %h/%h",
				$time, idx, result.y1, result.y2, result.y1_channel, result.y2_channel,
				p.exp.y1, p.exp.y2, p.exp.y1_channel, p.exp.y2_channel);
		end
		assert (irq_out === p.exp_irq) else begin
			errors++;
			$display("[ERROR] %0t ns: pattern %0d irq_out %h, expected %h",
				$time, idx, irq_out, p.exp_irq);
		end
		assert (tag_out === etag) else begin
			errors++;
			$display("[ERROR] %0t ns: pattern %0d tag_out %h, expected %h",
				$time, idx, tag_out, etag);
		end
	endtask

	initial begin
		rst        = 1'b1;
		hold       = 1'b0;
		req        = '0; // nonzero move while in reset
		req.mode   = exec_pkg::MODE_MOVE;
		req.x2     = 32'h5a5a_5a5a;
		req.y1_sel = 4'hf;
		req.y2_sel = 2'd2;
		tag_in     = '1;
		irq_in     = '1;
		exp_tag    = '0;
		load_patterns();
		loaded = 1'b1;
		repeat (16) @(posedge clk);
		@(negedge clk);
		assert (result === '0 && tag_out === '0 && irq_out === '0) else begin
			errors++;
			$display("[ERROR] %0t ns: outputs not zero after reset", $time);
		end
		rst = 1'b0;
		foreach (pats[i]) begin
			hold   = pats[i].hold;
			req    = pats[i].req;
			tag_in = pats[i].tag;
			irq_in = pats[i].irq;
			if (!pats[i].hold)
				exp_tag = pats[i].tag;
			@(negedge clk);
			check_line(i, pats[i], exp_tag);
		end
		$display("%0d errors over %0d pattern lines", errors, pats.size());
		if (errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

	// 20 cycles per line plus reset and one spare line
	initial begin
		wait (loaded);
		#((pats.size() + 1) * 20 * 8 + 16 * 8);
		$display("timeout: the pattern run did not finish in time");
		$display("ERRORS FOUND");
		$finish;
	end

endmodule

// File: exec_patterns.txt
# hold mode sub rw x1 x2 m l ys1 ys2 addr flg iv in | expected y1 y2 y1ch y2ch irq_valid irq_num
# all hex, bar not written; expected tag_out is the tag of the last line with hold low
0 05 0 0 80000001 00000005 00 00 3 1 00001000 81 0 00 00000020 00000010 3 1 0 00
0 05 1 0 80000013 00000005 00 00 4 2 00001004 80 0 00 04000000 98000000 4 2 0 00
0 05 2 0 80000001 00000005 00 00 3 1 00001008 c0 0 00 00000030 00000010 3 1 0 00
0 05 3 0 80000013 00000005 00 00 4 2 0000100c 80 0 00 9c000000 98000000 4 2 0 00
0 05 0 0 12345678 00000000 00 00 5 0 00001010 80 0 00 12345678 00000000 5 0 0 00
0 05 0 0 12345678 00000020 00 00 5 0 00001014 80 0 00 00000000 12345678 5 0 0 00
0 05 3 0 12345678 00000020 00 00 6 1 00001018 80 0 00 12345678 12345678 6 1 0 00
0 05 1 0 00000000 00000028 00 00 5 2 0000101c 80 0 00 00000000 00000000 0 0 1 07
0 05 0 0 00000000 00000028 00 00 5 2 00001020 a5 1 21 00000000 00000000 0 0 1 21
0 06 0 0 f0f000ff 0ff00f0f 00 00 1 1 00001024 80 0 00 00f0000f 00000001 1 1 0 00
0 06 1 0 00000000 00000000 00 00 2 1 00001028 80 0 00 00000000 00000000 2 1 0 00
0 06 2 0 00000000 0000ffff 00 00 2 1 0000102c 80 0 00 ffff0000 00000000 2 1 0 00
0 06 3 0 a5a5a5a5 00000000 00 00 2 1 00001030 80 0 00 a5a5a5a5 00000001 2 1 0 00
0 13 0 0 ffffffff 00000005 0b 08 7 0 00001034 80 0 00 fffff5ff 00000000 7 0 0 00
0 13 1 0 00000000 12345678 0f 04 7 0 00001038 80 0 00 00000567 00000000 7 0 0 00
0 09 0 0 00000000 deadbeef 00 00 8 0 0000103c 80 0 00 deadbeef 00000000 8 0 0 00
0 09 1 0 00001234 00005678 00 00 8 0 00001040 80 0 00 12345678 00000000 8 0 0 00
0 12 0 0 00000000 00000080 00 00 9 0 00001044 80 0 00 ffffff80 00000000 9 0 0 00
0 12 1 0 00000000 00007fff 00 00 9 0 00001048 80 0 00 00007fff 00000000 9 0 0 00
0 04 3 0 00000000 00000001 00 00 a 0 0000104c 80 0 00 ffffffff 00000000 a 0 0 00
0 14 0 0 ffffffff 00000001 00 00 0 1 00001050 80 0 00 00000000 00000000 0 1 0 00
0 14 1 0 ffffffff 00000001 00 00 0 1 00001054 80 0 00 00000000 00000001 0 1 0 00
0 14 2 0 ffffffff 00000001 00 00 0 1 00001058 80 0 00 00000000 00000001 0 1 0 00
0 14 3 0 ffffffff 00000001 00 00 0 1 0000105c 80 0 00 00000000 00000000 0 1 0 00
0 14 0 1 ffffffff 00000001 00 00 0 1 00001060 80 0 00 00000000 00000001 0 1 0 00
0 14 1 1 ffffffff 00000001 00 00 0 1 00001064 80 0 00 00000000 00000000 0 1 0 00
0 15 0 0 ffffffff 00000001 00 00 0 1 00001068 80 0 00 00000000 00000000 0 1 0 00
0 15 1 0 ffffffff 00000001 00 00 0 1 0000106c 80 0 00 00000000 00000001 0 1 0 00
0 15 2 0 ffffffff 00000001 00 00 0 1 00001070 80 0 00 00000000 00000000 0 1 0 00
0 15 3 0 ffffffff 00000001 00 00 0 1 00001074 80 0 00 00000000 00000001 0 1 0 00
0 15 0 1 ffffffff 00000001 00 00 0 1 00001078 80 0 00 00000000 00000000 0 1 0 00
0 15 1 1 ffffffff 00000001 00 00 0 1 0000107c 80 0 00 00000000 00000001 0 1 0 00
1 09 0 0 00000000 11111111 00 00 8 0 00001080 ff 1 33 00000000 00000001 0 1 0 00
0 0a 0 0 12345678 12345678 00 00 7 1 00001084 80 0 00 00000000 00000000 0 0 0 00

// File: exec_stage.f
exec_pkg.sv
shift_unit.sv
bitop_unit.sv
compare_unit.sv
exec_pipe_reg.sv
exec_stage.sv
exec_stage_sva.sv
exec_stage_tb.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ns --top-module exec_stage_tb \
	-f exec_stage.f -o sim_exec || exit 1
./obj_dir/sim_exec > sim.log 2>&1
cat sim.log
! grep -q "ERRORS FOUND" sim.log && grep -q "NO ERRORS" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
